// File: tb.f
rtl/axi_ahb_pkg.sv
rtl/axi_cmd_front.sv
rtl/ahb_byte_sequencer.sv
rtl/ahb_master_fsm.sv
rtl/axi_resp_gen.sv
rtl/axi4_to_ahb.sv
sim/tb_clk_gen.sv
sim/ahb_mem_model.sv
sim/tb_axi4_to_ahb.sv

// File: Bender.yml
package:
  name: axi4_to_ahb

sources:
  - rtl/axi_ahb_pkg.sv
  - rtl/axi_cmd_front.sv
  - rtl/ahb_byte_sequencer.sv
  - rtl/ahb_master_fsm.sv
  - rtl/axi_resp_gen.sv
  - rtl/axi4_to_ahb.sv
  - target: simulation
    files:
      - sim/tb_clk_gen.sv
      - sim/ahb_mem_model.sv
      - sim/tb_axi4_to_ahb.sv

// File: sim/tb_axi4_to_ahb.sv
`timescale 1ns/1ps
module tb_axi4_to_ahb
   import axi_ahb_pkg::*;
;
   localparam int                N_TXN    = 59;
   localparam logic [ADDR_W-1:0] ERR_BASE = 32'h0000_F000;

   logic              clk;
   logic              arst_n;
   logic              awvalid;
   logic              awready;
   logic [3:0]        awid;
   logic [ADDR_W-1:0] awaddr;
   logic [2:0]        awsize;
   logic              wvalid;
   logic              wready;
   logic [DATA_W-1:0] wdata;
   logic [STRB_W-1:0] wstrb;
   logic              wlast;
   logic              bvalid;
   logic              bready;
   logic [1:0]        bresp;
   logic [3:0]        bid;
   logic              arvalid;
   logic              arready;
   logic [3:0]        arid;
   logic [ADDR_W-1:0] araddr;
   logic [2:0]        arsize;
   logic              rvalid;
   logic              rready;
   logic [3:0]        rid;
   logic [DATA_W-1:0] rdata;
   logic [1:0]        rresp;
   logic              rlast;
   logic [ADDR_W-1:0] haddr;
   logic [2:0]        hburst;
   logic              hmastlock;
   logic [3:0]        hprot;
   logic [2:0]        hsize;
   logic [1:0]        htrans;
   logic              hwrite;
   logic [DATA_W-1:0] hwdata;
   logic [DATA_W-1:0] hrdata;
   logic              hready;
   logic              hresp;

   logic [DATA_W-1:0] ref_mem [256];
   logic [31:0]       rng;
   int                err_count;

   tb_clk_gen u_clk (.clk(clk), .arst_n(arst_n));

   axi4_to_ahb #(.ID_W(4)) u_dut (.*);

   ahb_mem_model u_mem (.*);

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Helpers.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   function automatic logic [31:0] xorshift32(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      return y ^ (y << 5);
   endfunction

   function automatic int count_ones(input logic [7:0] s);
      int n;
      n = 0;
      for (int i = 0; i < 8; i++) n += s[i];
      return n;
   endfunction

   function automatic int lowest_set(input logic [7:0] s);
      for (int i = 0; i < 8; i++) begin
         if (s[i]) return i;
      end
      return 0;
   endfunction

   function automatic logic [63:0] merge(input logic [63:0] old, input logic [63:0] d,
                                         input logic [7:0] s);
      logic [63:0] m;
      m = old;
      for (int i = 0; i < 8; i++) begin
         if (s[i]) m[8*i +: 8] = d[8*i +: 8];
      end
      return m;
   endfunction

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         err_count++;
         $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
         $display("Errors found");
         $fatal(1);
      end
   endtask

   task automatic timeout_fail(input string what);
      $display("Timeout: %s never arrived", what);
      $display("Errors found");
      $fatal(1);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // AXI channel drivers. Outputs are sampled 1 ns after the falling edge.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic send_aw(input logic [3:0] id, input logic [31:0] addr);
      int n;
      n = 0;
      @(negedge clk);
      awvalid = 1'b1;
      awid    = id;
      awaddr  = addr;
      awsize  = 3'd3;
      #1;
      while (!awready) begin
         n++;
         if (n > 200) timeout_fail("awready");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      awvalid = 1'b0;
   endtask

   task automatic send_w(input logic [63:0] d, input logic [7:0] s);
      int n;
      n = 0;
      @(negedge clk);
      wvalid = 1'b1;
      wdata  = d;
      wstrb  = s;
      wlast  = 1'b1;
      #1;
      while (!wready) begin
         n++;
         if (n > 200) timeout_fail("wready");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      wvalid = 1'b0;
   endtask

   task automatic finish_ar();
      int n;
      n = 0;
      #1;
      while (!arready) begin
         n++;
         if (n > 200) timeout_fail("arready");
         @(negedge clk);
         #1;
      end
      @(negedge clk);
      arvalid = 1'b0;
   endtask

   task automatic wait_count(input int target);
      int n;
      n = 0;
      while (u_mem.count < target) begin
         n++;
         if (n > 200) timeout_fail("AHB transfer");
         @(negedge clk);
      end
   endtask

   task automatic wait_b(input logic [3:0] id, input logic [1:0] resp);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         #1;
         n++;
         if (n > 200) timeout_fail("bvalid");
      end while (!bvalid);
      check("bid", bid, id);
      check("bresp", bresp, resp);
   endtask

   task automatic wait_r(input logic [3:0] id, input logic [31:0] addr);
      int n;
      n = 0;
      do begin
         @(negedge clk);
         #1;
         n++;
         if (n > 200) timeout_fail("rvalid");
      end while (!rvalid);
      check("rid", rid, id);
      check("rlast", rlast, 1'b1);
      check("rresp", rresp, (addr >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY);
      if (addr < ERR_BASE) check("rdata", rdata, ref_mem[addr[10:3]]);
   endtask

   task automatic write_txn(input logic [3:0] id, input logic [31:0] addr,
                            input logic [63:0] d, input logic [7:0] s, input bit aw_first);
      if (aw_first) begin
         send_aw(id, addr);
         send_w(d, s);
      end else begin
         send_w(d, s);
         send_aw(id, addr);
      end
      wait_b(id, (addr >= ERR_BASE) ? RESP_SLVERR : RESP_OKAY);
      if (addr < ERR_BASE) ref_mem[addr[10:3]] = merge(ref_mem[addr[10:3]], d, s);
   endtask

   task automatic read_txn(input logic [3:0] id, input logic [31:0] addr);
      @(negedge clk);
      arvalid = 1'b1;
      arid    = id;
      araddr  = addr;
      arsize  = 3'd3;
      finish_ar();
      wait_r(id, addr);
   endtask

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Directed tests.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   task automatic test_full_write_read();
      write_txn(4'h3, 32'h0000_0080, 64'h0123_4567_89AB_CDEF, 8'hFF, 1'b1);
      check("hburst", hburst, 3'b000);  // Single transfers only.
      check("hmastlock", hmastlock, 1'b0);
      check("hprot", hprot, 4'b0011);
      read_txn(4'h5, 32'h0000_0080);
   endtask

   task automatic aligned_write(input logic [31:0] addr, input logic [7:0] s);
      int c0;
      int sz;
      c0 = u_mem.count;
      sz = (count_ones(s) == 8) ? 3 : (count_ones(s) == 4) ? 2 : 1;
      write_txn(4'h1, addr, 64'hFEDC_BA98_7654_3210, s, 1'b1);
      check("aligned transfer count", u_mem.count, c0 + 1);
      check("aligned hsize", u_mem.log_size[c0], sz);
      check("aligned haddr", u_mem.log_addr[c0], addr + lowest_set(s));
   endtask

   task automatic test_aligned_partial();
      aligned_write(32'h0000_0100, 8'h0F);
      aligned_write(32'h0000_0100, 8'hC0);
      aligned_write(32'h0000_0100, 8'h30);
      read_txn(4'h2, 32'h0000_0100);
   endtask

   task automatic test_split_write();
      int c0;
      int k;
      c0 = u_mem.count;
      k  = 0;
      write_txn(4'h4, 32'h0000_0180, 64'h1122_3344_5566_7788, 8'h5A, 1'b1);
      check("split transfer count", u_mem.count, c0 + count_ones(8'h5A));
      for (int i = 0; i < 8; i++) begin
         if (8'h5A & (8'h01 << i)) begin
            check("split haddr", u_mem.log_addr[c0 + k], 32'h0000_0180 + i);
            check("split hsize", u_mem.log_size[c0 + k], 0);
            k++;
         end
      end
      read_txn(4'h4, 32'h0000_0180);
   endtask

   task automatic test_error_range();
      int c0;
      c0 = u_mem.count;
      write_txn(4'h2, 32'h0000_F008, 64'hDEAD_0000_0000_BEEF, 8'hFF, 1'b1);
      write_txn(4'h2, 32'h0000_F010, 64'hDEAD_0000_0000_BEEF, 8'h5A, 1'b0);
      check("error cancels bytes", u_mem.count, c0 + 2);
      read_txn(4'h3, 32'h0000_F100);
      write_txn(4'h9, 32'h0000_0040, 64'hA5A5_5A5A_0F0F_F0F0, 8'hFF, 1'b1);
      read_txn(4'hA, 32'h0000_0040);
   endtask

   task automatic test_backpressure();
      int c0;
      int c1;
      c0 = u_mem.count;
      write_txn(4'h6, 32'h0000_0200, 64'h0000_1111_2222_3333, 8'h3C, 1'b1);
      c1 = u_mem.count - c0;
      write_txn(4'h6, 32'h0000_0208, 64'h0000_1111_2222_3333, 8'h3C, 1'b0);
      check("W before AW transfer count", u_mem.count - c0, 2 * c1);
      read_txn(4'h6, 32'h0000_0200);
      read_txn(4'h6, 32'h0000_0208);
      c0 = u_mem.count;
      @(negedge clk);
      bready = 1'b0;
      send_aw(4'h7, 32'h0000_0300);
      send_w(64'h7777_6666_5555_4444, 8'hFF);
      wait_count(c0 + 1);
      @(negedge clk);
      arvalid = 1'b1;
      arid    = 4'h8;
      araddr  = 32'h0000_0300;
      arsize  = 3'd3;
      repeat (20) begin
         @(negedge clk);
         #1;
         check("bvalid while bready low", bvalid, 1'b0);
         check("arready while held", arready, 1'b0);
         check("transfers while held", u_mem.count, c0 + 1);
      end
      @(negedge clk);
      bready = 1'b1;
      #1;
      check("held bvalid", bvalid, 1'b1);
      check("held bid", bid, 4'h7);
      check("held bresp", bresp, RESP_OKAY);
      ref_mem[8'h60] = 64'h7777_6666_5555_4444;
      finish_ar();
      wait_r(4'h8, 32'h0000_0300);
   endtask

   task automatic test_random();
      logic [31:0] addr;
      logic [63:0] d;
      logic [7:0]  s;
      for (int i = 0; i < 40; i++) begin
         rng  = xorshift32(rng);
         addr = {21'd0, rng[10:3], 3'd0};
         d[63:32] = xorshift32(rng);
         d[31:0]  = xorshift32(d[63:32]);
         s = d[7:0] ^ d[47:40];
         if (s == 8'h00) s = 8'hFF;
         if (rng[0]) write_txn(rng[15:12], addr, d, s, rng[1]);
         else read_txn(rng[15:12], addr);
      end
   endtask

   initial begin
      repeat (N_TXN * 200 + 8) @(posedge clk);
      $display("Watchdog expired before the test sequence finished");
      $display("Errors found");
      $fatal(1);
   end

   initial begin
      err_count = 0;
      rng       = 32'd84;
      awvalid   = 1'b0;
      awid      = '0;
      awaddr    = '0;
      awsize    = 3'd3;
      wvalid    = 1'b0;
      wdata     = '0;
      wstrb     = '0;
      wlast     = 1'b0;
      bready    = 1'b1;
      arvalid   = 1'b0;
      arid      = '0;
      araddr    = '0;
      arsize    = 3'd3;
      rready    = 1'b1;
      for (int i = 0; i < 256; i++) begin
         ref_mem[i] = {32'(i * 8) ^ 32'h5A00_0000, ~32'(i * 8)};
      end
      @(posedge arst_n);
      test_full_write_read();
      test_aligned_partial();
      test_split_write();
      test_error_range();
      test_backpressure();
      test_random();
      if (err_count == 0) begin
         $display("No errors");
      end else begin
         $display("Errors found");
      end
      $finish;
   end
endmodule

// File: sim/ahb_mem_model.sv
`timescale 1ns/1ps
module ahb_mem_model
   import axi_ahb_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic [ADDR_W-1:0] haddr,
   input  logic [1:0]        htrans,
   input  logic [2:0]        hsize,
   input  logic              hwrite,
   input  logic [DATA_W-1:0] hwdata,
   output logic [DATA_W-1:0] hrdata,
   output logic              hready,
   output logic              hresp
);
   localparam logic [ADDR_W-1:0] ERR_BASE = 32'h0000_F000;

   logic [DATA_W-1:0] mem [256];
   logic [ADDR_W-1:0] log_addr [128];
   logic [2:0]        log_size [128];
   int                count;
   logic              dp;
   logic              stall;
   logic              dp_err;
   logic              dp_write;
   logic              wait_tog;
   logic [ADDR_W-1:0] dp_addr;
   logic [2:0]        dp_size;

   initial begin
      for (int i = 0; i < 256; i++) begin
         mem[i] = {32'(i * 8) ^ 32'h5A00_0000, ~32'(i * 8)};  // Word fill from its address.
      end
   end

   assign hready = ~dp | ~stall;
   assign hresp  = dp & dp_err;  // The error response takes two cycles with hready low first.

   always @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         dp       <= 1'b0;
         stall    <= 1'b0;
         dp_err   <= 1'b0;
         wait_tog <= 1'b0;
         count    <= 0;
         hrdata   <= '0;
      end else begin
         if (dp && stall) begin
            stall <= 1'b0;
         end else if (dp) begin
            if (dp_write && !dp_err) begin
               for (int l = 0; l < 8; l++) begin
                  if (l >= dp_addr[2:0] && l < dp_addr[2:0] + (1 << dp_size)) begin
                     mem[dp_addr[10:3]][8*l +: 8] <= hwdata[8*l +: 8];
                  end
               end
            end
            dp <= 1'b0;
         end
         if (htrans == HTRANS_NONSEQ && hready) begin
            dp       <= 1'b1;
            dp_addr  <= haddr;
            dp_size  <= hsize;
            dp_write <= hwrite;
            dp_err   <= (haddr >= ERR_BASE);
            stall    <= (haddr >= ERR_BASE) | wait_tog;
            wait_tog <= ~wait_tog;
            if (count < 128) begin
               log_addr[count] <= haddr;
               log_size[count] <= hsize;
            end
            count <= count + 1;
            if (!hwrite && haddr < ERR_BASE) begin
               hrdata <= mem[haddr[10:3]];
            end
         end
      end
   end
endmodule

// File: sim/tb_clk_gen.sv
`timescale 1ns/1ps
module tb_clk_gen #(
   parameter real PERIOD_NS   = 10.0,
   parameter int  RST_CYCLES  = 8
) (
   output logic clk,
   output logic arst_n
);
   initial begin
      clk = 1'b0;
      forever #(PERIOD_NS / 2.0) clk = ~clk;
   end

   initial begin
      arst_n = 1'b0;
      repeat (RST_CYCLES) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;  // Released away from the active edge.
   end
endmodule

// File: rtl/axi4_to_ahb.sv
`timescale 1ns/1ps
module axi4_to_ahb
   import axi_ahb_pkg::*;
#(
   parameter int ID_W = 1
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              awvalid,
   output logic              awready,
   input  logic [ID_W-1:0]   awid,
   input  logic [ADDR_W-1:0] awaddr,
   input  logic [2:0]        awsize,
   input  logic              wvalid,
   output logic              wready,
   input  logic [DATA_W-1:0] wdata,
   input  logic [STRB_W-1:0] wstrb,
   input  logic              wlast,
   output logic              bvalid,
   input  logic              bready,
   output logic [1:0]        bresp,
   output logic [ID_W-1:0]   bid,
   input  logic              arvalid,
   output logic              arready,
   input  logic [ID_W-1:0]   arid,
   input  logic [ADDR_W-1:0] araddr,
   input  logic [2:0]        arsize,
   output logic              rvalid,
   input  logic              rready,
   output logic [ID_W-1:0]   rid,
   output logic [DATA_W-1:0] rdata,
   output logic [1:0]        rresp,
   output logic              rlast,
   output logic [ADDR_W-1:0] haddr,
   output logic [2:0]        hburst,
   output logic              hmastlock,
   output logic [3:0]        hprot,
   output logic [2:0]        hsize,
   output logic [1:0]        htrans,
   output logic              hwrite,
   output logic [DATA_W-1:0] hwdata,
   input  logic [DATA_W-1:0] hrdata,
   input  logic              hready,
   input  logic              hresp
);
   logic              cmd_valid;
   logic              cmd_ready;
   logic              cmd_write;
   logic [ID_W-1:0]   cmd_id;
   logic [ADDR_W-1:0] cmd_addr;
   logic [2:0]        cmd_size;
   logic [DATA_W-1:0] cmd_wdata;
   logic [STRB_W-1:0] cmd_strb;

   logic              in_aligned;
   logic [2:0]        in_size_eff;
   logic [2:0]        in_low_addr;
   logic [2:0]        start_ptr;
   logic [2:0]        hsize_low;
   logic [2:0]        ptr;
   logic              last_beat;
   logic              load;
   logic              step;
   logic [2:0]        buf_size;
   logic [STRB_W-1:0] buf_strb;
   logic              buf_aligned;

   logic              rsp_load;
   logic              rsp_write;
   logic [ID_W-1:0]   rsp_id;
   logic              rsp_error;
   logic [DATA_W-1:0] rsp_rdata;
   logic              rsp_taken;

   axi_cmd_front #(.ID_W(ID_W)) u_front (.*);

   // The sequencer sees the incoming command so sizes are ready at acceptance.
   ahb_byte_sequencer u_seq (
      .in_size  (cmd_size),
      .in_strb  (cmd_strb),
      .in_write (cmd_write),
      .*
   );

   ahb_master_fsm #(.ID_W(ID_W)) u_fsm (.*);

   axi_resp_gen #(.ID_W(ID_W)) u_rsp (.*);

endmodule

// File: rtl/axi_resp_gen.sv
`timescale 1ns/1ps
module axi_resp_gen
   import axi_ahb_pkg::*;
#(
   parameter int ID_W = 1
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              rsp_load,
   input  logic              rsp_write,
   input  logic [ID_W-1:0]   rsp_id,
   input  logic              rsp_error,
   input  logic [DATA_W-1:0] rsp_rdata,
   input  logic              bready,
   input  logic              rready,
   output logic              rsp_taken,
   output logic              bvalid,
   output logic [ID_W-1:0]   bid,
   output logic [1:0]        bresp,
   output logic              rvalid,
   output logic [ID_W-1:0]   rid,
   output logic [DATA_W-1:0] rdata,
   output logic [1:0]        rresp,
   output logic              rlast
);
   logic              held;
   logic              held_write;
   logic              held_error;
   logic [ID_W-1:0]   held_id;
   logic [DATA_W-1:0] held_rdata;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         held <= 1'b0;
      end else if (rsp_load) begin
         held <= 1'b1;
      end else if (rsp_taken) begin
         held <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rsp_load) begin
         held_write <= rsp_write;
         held_error <= rsp_error;
         held_id    <= rsp_id;
         held_rdata <= rsp_rdata;
      end
   end

   // Both channels must be ready before either response goes out.
   assign rsp_taken = held & bready & rready;

   assign bvalid = rsp_taken & held_write;
   assign rvalid = rsp_taken & ~held_write;
   assign bresp  = held_error ? RESP_SLVERR : RESP_OKAY;
   assign rresp  = held_error ? RESP_SLVERR : RESP_OKAY;
   assign bid    = held_id;
   assign rid    = held_id;
   assign rdata  = held_rdata;
   assign rlast  = 1'b1;

endmodule

// File: rtl/ahb_master_fsm.sv
`timescale 1ns/1ps
module ahb_master_fsm
   import axi_ahb_pkg::*;
#(
   parameter int ID_W = 1
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              cmd_valid,
   input  logic              cmd_write,
   input  logic [ID_W-1:0]   cmd_id,
   input  logic [ADDR_W-1:0] cmd_addr,
   input  logic [2:0]        cmd_size,
   input  logic [DATA_W-1:0] cmd_wdata,
   input  logic [STRB_W-1:0] cmd_strb,
   output logic              cmd_ready,
   input  logic              in_aligned,
   input  logic [2:0]        in_size_eff,
   input  logic [2:0]        in_low_addr,
   input  logic [2:0]        start_ptr,
   input  logic [2:0]        hsize_low,
   input  logic [2:0]        ptr,
   input  logic              last_beat,
   output logic              load,
   output logic              step,
   output logic [2:0]        buf_size,
   output logic [STRB_W-1:0] buf_strb,
   output logic              buf_aligned,
   output logic [ADDR_W-1:0] haddr,
   output logic [1:0]        htrans,
   output logic [2:0]        hsize,
   output logic              hwrite,
   output logic [DATA_W-1:0] hwdata,
   output logic [2:0]        hburst,
   output logic              hmastlock,
   output logic [3:0]        hprot,
   input  logic [DATA_W-1:0] hrdata,
   input  logic              hready,
   input  logic              hresp,
   output logic              rsp_load,
   output logic              rsp_write,
   output logic [ID_W-1:0]   rsp_id,
   output logic              rsp_error,
   output logic [DATA_W-1:0] rsp_rdata,
   input  logic              rsp_taken
);
   bridge_state_e     state;
   bridge_state_e     state_nxt;
   logic              active;
   logic              hready_q;
   logic              hresp_q;
   logic [1:0]        htrans_q;
   logic              buf_write;
   logic [ID_W-1:0]   buf_id;
   logic [ADDR_W-1:0] buf_addr;
   logic [DATA_W-1:0] buf_data;
   logic [DATA_W-1:0] rdata_q;
   logic [2:0]        low_addr_in;
   logic              addr_done;
   logic              data_done;
   logic              finish;

   assign cmd_ready = active & (state == IDLE);
   assign load      = cmd_valid & cmd_ready;

   assign addr_done = hready_q & (htrans_q == HTRANS_NONSEQ);  // Address phase taken.
   assign data_done = hready_q | hresp_q;
   assign finish    = hresp_q | (state == DATA_RD) | last_beat;
   assign step      = (state == DATA_WR) & data_done & ~finish;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Transaction FSM.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   always_comb begin
      state_nxt = state;
      htrans    = HTRANS_IDLE;
      rsp_load  = 1'b0;
      case (state)
         IDLE: begin
            if (load) begin
               state_nxt = cmd_write ? CMD_WR : CMD_RD;
            end
         end
         CMD_RD, CMD_WR: begin
            htrans = addr_done ? HTRANS_IDLE : HTRANS_NONSEQ;
            if (addr_done) begin
               state_nxt = (state == CMD_RD) ? DATA_RD : DATA_WR;
            end
         end
         DATA_RD, DATA_WR: begin
            if (data_done && finish) begin
               state_nxt = DONE;  // An error also drops any remaining bytes.
               rsp_load  = 1'b1;
            end else if (data_done) begin
               state_nxt = CMD_WR;
            end
         end
         DONE: begin
            if (rsp_taken) begin
               state_nxt = IDLE;
            end
         end
         default: state_nxt = IDLE;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state     <= IDLE;
         active    <= 1'b0;
         hready_q  <= 1'b0;
         hresp_q   <= 1'b0;
         htrans_q  <= HTRANS_IDLE;
         buf_write <= 1'b0;
      end else begin
         state    <= state_nxt;
         active   <= 1'b1;
         hready_q <= hready;
         hresp_q  <= hresp;
         htrans_q <= htrans;
         if (load) begin
            buf_write <= cmd_write;
         end
      end
   end

   // Split writes take their address from the pointer, so only aligned low bits matter.
   assign low_addr_in = !in_aligned ? start_ptr :
                        (cmd_write && cmd_size == 3'd3) ? in_low_addr : cmd_addr[2:0];

   always_ff @(posedge clk) begin
      if (load) begin
         buf_id      <= cmd_id;
         buf_addr    <= {cmd_addr[ADDR_W-1:3], low_addr_in};
         buf_size    <= in_size_eff;
         buf_strb    <= cmd_strb;
         buf_aligned <= in_aligned;
         buf_data    <= cmd_wdata;
      end
      if (hready && state inside {CMD_RD, DATA_RD}) begin
         rdata_q <= hrdata;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // AHB master outputs and response.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign haddr     = {buf_addr[ADDR_W-1:3], buf_aligned ? buf_addr[2:0] : ptr};
   assign hsize     = hsize_low;
   assign hwrite    = buf_write;
   assign hwdata    = buf_data;  // Held for the whole transaction.
   assign hburst    = HBURST_SINGLE;
   assign hmastlock = 1'b0;
   assign hprot     = HPROT_DATA;

   assign rsp_write = buf_write;
   assign rsp_id    = buf_id;
   assign rsp_error = hresp_q;
   assign rsp_rdata = rdata_q;

endmodule

// File: rtl/ahb_byte_sequencer.sv
`timescale 1ns/1ps
module ahb_byte_sequencer
   import axi_ahb_pkg::*;
(
   input  logic              clk,
   input  logic              arst_n,
   input  logic [2:0]        in_size,
   input  logic [STRB_W-1:0] in_strb,
   input  logic              in_write,
   input  logic              load,
   input  logic              step,
   input  logic [2:0]        buf_size,
   input  logic [STRB_W-1:0] buf_strb,
   input  logic              buf_aligned,
   output logic              in_aligned,
   output logic [2:0]        in_size_eff,
   output logic [2:0]        in_low_addr,
   output logic [2:0]        start_ptr,
   output logic [2:0]        hsize_low,
   output logic [2:0]        ptr,
   output logic              last_beat
);
   logic       strb_match;
   logic [2:0] strb_size;
   logic [2:0] next_ptr;

   // Naturally aligned strobe groups map to a single transfer.
   always_comb begin
      strb_match  = 1'b1;
      strb_size   = 3'd1;
      in_low_addr = 3'd0;
      case (in_strb)
         8'hFF: strb_size = 3'd3;
         8'h0F: strb_size = 3'd2;
         8'hF0: begin
            strb_size   = 3'd2;
            in_low_addr = 3'd4;
         end
         8'h03: in_low_addr = 3'd0;
         8'h0C: in_low_addr = 3'd2;
         8'h30: in_low_addr = 3'd4;
         8'hC0: in_low_addr = 3'd6;
         default: strb_match = 1'b0;
      endcase
   end

   assign in_aligned  = ~in_write | (in_size < 3'd3) | strb_match;
   assign in_size_eff = (in_write && in_size == 3'd3 && strb_match) ? strb_size : in_size;

   always_comb begin
      start_ptr = 3'd0;
      next_ptr  = ptr;
      for (int i = STRB_W - 1; i >= 0; i--) begin
         if (in_strb[i]) begin
            start_ptr = 3'(i);
         end
         if (buf_strb[i] && 3'(i) > ptr) begin
            next_ptr = 3'(i);  // Lowest set strobe above the pointer wins.
         end
      end
   end

   assign hsize_low = buf_aligned ? buf_size : 3'd0;
   assign last_beat = buf_aligned | ~|(buf_strb >> ptr >> 1);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr <= 3'd0;
      end else if (load) begin
         ptr <= start_ptr;
      end else if (step) begin
         ptr <= next_ptr;
      end
   end

endmodule

// File: rtl/axi_cmd_front.sv
`timescale 1ns/1ps
module axi_cmd_front
   import axi_ahb_pkg::*;
#(
   parameter int ID_W = 1
) (
   input  logic              clk,
   input  logic              arst_n,
   input  logic              awvalid,
   input  logic [ID_W-1:0]   awid,
   input  logic [ADDR_W-1:0] awaddr,
   input  logic [2:0]        awsize,
   output logic              awready,
   input  logic              wvalid,
   input  logic [DATA_W-1:0] wdata,
   input  logic [STRB_W-1:0] wstrb,
   input  logic              wlast,
   output logic              wready,
   input  logic              arvalid,
   input  logic [ID_W-1:0]   arid,
   input  logic [ADDR_W-1:0] araddr,
   input  logic [2:0]        arsize,
   output logic              arready,
   input  logic              cmd_ready,
   output logic              cmd_valid,
   output logic              cmd_write,
   output logic [ID_W-1:0]   cmd_id,
   output logic [ADDR_W-1:0] cmd_addr,
   output logic [2:0]        cmd_size,
   output logic [DATA_W-1:0] cmd_wdata,
   output logic [STRB_W-1:0] cmd_strb
);
   logic              aw_vld;
   logic              w_vld;
   logic [ID_W-1:0]   aw_id;
   logic [ADDR_W-1:0] aw_addr;
   logic [2:0]        aw_size;
   logic [DATA_W-1:0] w_data;
   logic [STRB_W-1:0] w_strb;
   logic              wr_cmd_vld;
   logic              wr_sent;
   logic              aw_en;
   logic              w_en;

   assign wr_cmd_vld = aw_vld & w_vld;
   assign wr_sent    = wr_cmd_vld & cmd_ready;

   assign awready = cmd_ready & (~aw_vld | wr_sent);
   assign wready  = cmd_ready & (~w_vld | wr_sent);
   assign arready = cmd_ready & ~wr_cmd_vld;  // A buffered write goes first.

   assign aw_en = awvalid & awready;
   assign w_en  = wvalid & wready;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         aw_vld <= 1'b0;
         w_vld  <= 1'b0;
      end else begin
         if (aw_en) begin
            aw_vld <= 1'b1;
         end else if (wr_sent) begin
            aw_vld <= 1'b0;
         end
         if (w_en) begin
            w_vld <= wlast;  // Only the last beat completes the slot.
         end else if (wr_sent) begin
            w_vld <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (aw_en) begin
         aw_id   <= awid;
         aw_addr <= awaddr;
         aw_size <= awsize;
      end
      if (w_en) begin
         w_data <= wdata;
         w_strb <= wstrb;
      end
   end

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Command mux. Reads pass straight through from the AR channel.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   assign cmd_valid = wr_cmd_vld | arvalid;
   assign cmd_write = wr_cmd_vld;
   assign cmd_id    = wr_cmd_vld ? aw_id : arid;
   assign cmd_addr  = wr_cmd_vld ? aw_addr : araddr;
   assign cmd_size  = wr_cmd_vld ? aw_size : arsize;
   assign cmd_wdata = w_data;
   assign cmd_strb  = w_strb;

endmodule

// File: rtl/axi_ahb_pkg.sv
package axi_ahb_pkg;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // Bus widths.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam int ADDR_W = 32;
   localparam int DATA_W = 64;
   localparam int STRB_W = 8;

   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   // AHB and AXI codes.
   // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
   localparam logic [1:0] HTRANS_IDLE   = 2'b00;
   localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
   localparam logic [2:0] HBURST_SINGLE = 3'b000;
   localparam logic [3:0] HPROT_DATA    = 4'b0011;  // Privileged data access.

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   typedef enum logic [2:0] {
      IDLE,
      CMD_RD,
      DATA_RD,
      CMD_WR,
      DATA_WR,
      DONE
   } bridge_state_e;

endpackage
